/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbVgaGame
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard src/*.sv) $(wildcard tb/*.sv)
SIM  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# exit status of the binary is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

/* project.f */
src/vgaGamePkg.sv
src/tickGen.sv
src/gameControl.sv
src/playerMotion.sv
src/laserBank.sv
src/pixelRenderer.sv
src/vgaGame.sv
tb/tbVgaGame.sv

/* src/gameControl.sv */
`timescale 1ns/1ps
`default_nettype none

module gameControl
        import vgaGamePkg::*;
(
        input  wire        CLK,
        input  wire        ARST_L,
        input  wire  [7:0] kbCode_i,
        input  wire        kbStrobe_i,
        input  wire        landed_i,
        input  wire        atEdge_i,
        input  wire        slot0Exit_i,
        output moveCmd_t   moveCmd_o,
        output logic [1:0] fireSlot_o
);

        localparam speed_t WALK = 11'sd3;

        speed_t     xSpeed;
        logic       jumpKick;
        logic       moveRight;
        logic       moveLeft;
        logic [1:0] kickCount;
        logic [1:0] laserCount;
        logic       keyRight;
        logic       keyLeft;
        logic       kickOk;
        logic       fireOk;

        // decoded strobes
        assign keyRight = kbStrobe_i && (kbCode_i == KEY_RIGHT);
        assign keyLeft  = kbStrobe_i && (kbCode_i == KEY_LEFT);
        // no kick from an edge, at most three before landing
        assign kickOk   = kbStrobe_i && (kbCode_i == KEY_JUMP) && !atEdge_i
                          && (kickCount < 2'd3);
        assign fireOk   = kbStrobe_i && (kbCode_i == KEY_FIRE) && (laserCount < 2'd3);

        assign moveCmd_o = '{xSpeed: xSpeed, jumpKick: jumpKick};

        ////////////////////////////////////////////////////////////////////////////
        // walking, same key again stops
        always_ff @(posedge CLK or negedge ARST_L)
        begin
                if (!ARST_L)
                begin
                        xSpeed    <= '0;
                        moveRight <= 1'b0;
                        moveLeft  <= 1'b0;
                end
                else if (keyRight)
                begin
                        xSpeed    <= moveRight ? speed_t'(0) : WALK;
                        moveRight <= !moveRight;
                        moveLeft  <= 1'b0;
                end
                else if (keyLeft)
                begin
                        xSpeed    <= moveLeft ? speed_t'(0) : -WALK;
                        moveLeft  <= !moveLeft;
                        moveRight <= 1'b0;
                end
        end

        // jump kick pulse and kick count
        always_ff @(posedge CLK or negedge ARST_L)
        begin
                if (!ARST_L)
                begin
                        jumpKick  <= 1'b0;
                        kickCount <= '0;
                end
                else
                begin
                        jumpKick <= kickOk;
                        if (landed_i)
                                kickCount <= '0;
                        else if (kickOk)
                                kickCount <= kickCount + 2'd1;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // fire slots 1..3 in turn, slot 0 leaving frees the bank
        always_ff @(posedge CLK or negedge ARST_L)
        begin
                if (!ARST_L)
                begin
                        fireSlot_o <= 2'd0;
                        laserCount <= '0;
                end
                else
                begin
                        fireSlot_o <= fireOk ? laserCount + 2'd1 : 2'd0;
                        if (fireOk)
                                laserCount <= laserCount + 2'd1;
                        else if (slot0Exit_i)
                                laserCount <= '0;
                end
        end

endmodule

`default_nettype wire

/* src/laserBank.sv */
`timescale 1ns/1ps
`default_nettype none

module laserBank
        import vgaGamePkg::*;
(
        input  wire        CLK,
        input  wire        ARST_L,
        input  wire        frameTick_i,
        input  wire  [1:0] fireSlot_i,
        input  pos_t       playerPos_i,
        output pos_t       laserPos_o [NUM_LASERS],
        output logic       slot0Exit_o
);

        localparam coord_t STEP = 11'd5;

        logic [NUM_LASERS-1:0] atEast;
        pos_t                  muzzle;

        // spawn point at the barrel tip
        assign muzzle = '{x: playerPos_i.x + MUZZLE_DX, y: playerPos_i.y + MUZZLE_DY};

        always_comb
        begin
                for (int i = 0; i < NUM_LASERS; i++)
                        atEast[i] = laserPos_o[i].x >= EDGE_EAST;
        end

        ////////////////////////////////////////////////////////////////////////////
        // load, then clear, then advance
        always_ff @(posedge CLK or negedge ARST_L)
        begin
                if (!ARST_L)
                begin
                        for (int i = 0; i < NUM_LASERS; i++)
                                laserPos_o[i] <= '0;
                        slot0Exit_o <= 1'b0;
                end
                else
                begin
                        slot0Exit_o <= 1'b0;
                        if (fireSlot_i != 2'd0)
                                laserPos_o[fireSlot_i - 2'd1] <= muzzle;
                        else if (|atEast)
                        begin
                                // lasers past the east edge park at 0,0
                                for (int i = 0; i < NUM_LASERS; i++)
                                        if (atEast[i])
                                                laserPos_o[i] <= '0;
                                slot0Exit_o <= atEast[0];
                        end
                        else if (frameTick_i)
                        begin
                                for (int i = 0; i < NUM_LASERS; i++)
                                        laserPos_o[i].x <= laserPos_o[i].x + STEP;
                        end
                end
        end

endmodule

`default_nettype wire

/* src/pixelRenderer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelRenderer
        import vgaGamePkg::*;
(
        input  wire       CLK,
        input  wire       ARST_L,
        input  wire [9:0] hCoord_i,
        input  wire [9:0] vCoord_i,
        input  pos_t      playerPos_i,
        input  pos_t      laserPos_i [NUM_LASERS],
        output color_t    csel_o
);

        coord_t hc;
        coord_t vc;
        color_t pixColor;
        logic   hit;

        assign hc = {1'b0, hCoord_i};
        assign vc = {1'b0, vCoord_i};

        // half-open box test
        function automatic logic inBox(coord_t x0, coord_t x1, coord_t y0, coord_t y1);
                return (hc >= x0) && (hc < x1) && (vc >= y0) && (vc < y1);
        endfunction

        ////////////////////////////////////////////////////////////////////////////
        // sprite table first, lasers after, white otherwise
        always_comb
        begin
                pixColor = COL_BG;
                hit      = 1'b0;
                for (int i = 0; i < $size(SPRITE); i++)
                begin
                        if (!hit && inBox(playerPos_i.x + coord_t'(SPRITE[i].dx0),
                                          playerPos_i.x + coord_t'(SPRITE[i].dx1),
                                          playerPos_i.y + coord_t'(SPRITE[i].dy0),
                                          playerPos_i.y + coord_t'(SPRITE[i].dy1)))
                        begin
                                pixColor = SPRITE[i].color;
                                hit      = 1'b1;
                        end
                end
                // a laser parked on row 0 is idle and not drawn
                for (int j = 0; j < NUM_LASERS; j++)
                begin
                        if (!hit && (laserPos_i[j].y != '0)
                            && inBox(laserPos_i[j].x, laserPos_i[j].x + LASER_W,
                                     laserPos_i[j].y, laserPos_i[j].y + LASER_H))
                        begin
                                pixColor = COL_LASER;
                                hit      = 1'b1;
                        end
                end
        end

        // one clock from coordinate to colour
        always_ff @(posedge CLK or negedge ARST_L)
        begin
                if (!ARST_L)
                        csel_o <= COL_BG;
                else
                        csel_o <= pixColor;
        end

endmodule

`default_nettype wire

/* src/playerMotion.sv */
`timescale 1ns/1ps
`default_nettype none

module playerMotion
        import vgaGamePkg::*;
(
        input  wire       CLK,
        input  wire       ARST_L,
        input  wire       frameTick_i,
        input  wire       gravityTick_i,
        input  moveCmd_t  moveCmd_i,
        output pos_t      playerPos_o,
        output logic      landed_o,
        output logic      atEdge_o
);

        localparam speed_t KICK = 11'sd10;

        pos_t   pos;
        speed_t ySpeed;
        logic   colN;
        logic   colS;
        logic   colW;
        logic   colE;
        logic   onFloor;
        logic   clear;

        // edge contacts
        assign colN    = pos.y <= EDGE_MIN;
        assign colS    = pos.y >= EDGE_SOUTH;
        assign colW    = pos.x <= EDGE_MIN;
        assign colE    = pos.x >= EDGE_EAST;
        assign onFloor = pos.y >= FLOOR_Y;

        assign atEdge_o    = colN | colS | colW | colE;
        assign clear       = !(atEdge_o || onFloor);
        assign playerPos_o = pos;

        ////////////////////////////////////////////////////////////////////////////
        // vertical speed, kick beats gravity
        always_ff @(posedge CLK or negedge ARST_L)
        begin
                if (!ARST_L)
                begin
                        ySpeed   <= '0;
                        landed_o <= 1'b0;
                end
                else
                begin
                        landed_o <= gravityTick_i && (pos.y >= REST_Y);
                        if (moveCmd_i.jumpKick)
                                ySpeed <= ySpeed - KICK;
                        else if (gravityTick_i)
                                ySpeed <= (pos.y < REST_Y) ? ySpeed + speed_t'(1) : speed_t'(0);
                end
        end

        // position step or clamp, once per frame
        always_ff @(posedge CLK or negedge ARST_L)
        begin
                if (!ARST_L)
                        pos <= '{x: START_X, y: START_Y};
                else if (frameTick_i)
                begin
                        // negative speeds wrap through the 11-bit sum
                        if (clear)
                        begin
                                pos.x <= pos.x + coord_t'(moveCmd_i.xSpeed);
                                pos.y <= pos.y + coord_t'(ySpeed);
                        end
                        else if (colN)
                                pos.y <= EDGE_MIN + 11'd1;
                        else if (colS)
                                pos.y <= FLOOR_Y;
                        else if (colW)
                                pos.x <= EDGE_MIN + 11'd1;
                        else if (colE)
                                pos.x <= EDGE_EAST - 11'd1;
                        else
                                pos.y <= REST_Y;
                end
        end

endmodule

`default_nettype wire

/* src/tickGen.sv */
`timescale 1ns/1ps
`default_nettype none

module tickGen #(
        parameter int unsigned DIV = 250000
) (
        input  wire  CLK,
        input  wire  ARST_L,
        output logic tick_o
);

        localparam int CW = $clog2(DIV + 1);

        logic [CW-1:0] count;

        // count 0..DIV, pulse on the wrap
        always_ff @(posedge CLK or negedge ARST_L)
        begin
                if (!ARST_L)
                begin
                        count  <= '0;
                        tick_o <= 1'b0;
                end
                else if (count == CW'(DIV))
                begin
                        count  <= '0;
                        tick_o <= 1'b1;
                end
                else
                begin
                        count  <= count + 1'b1;
                        tick_o <= 1'b0;
                end
        end

endmodule

`default_nettype wire

/* src/vgaGame.sv */
`timescale 1ns/1ps
`default_nettype none

module vgaGame
        import vgaGamePkg::*;
#(
        parameter int unsigned FRAME_DIV   = 250000,
        parameter int unsigned GRAVITY_DIV = 1000000
) (
        input  wire       CLK,
        input  wire       ARST_L,
        input  wire [7:0] KBCODE,
        input  wire       KBSTROBE,
        input  wire [9:0] HCOORD,
        input  wire [9:0] VCOORD,
        output color_t    CSEL
);

        logic       frameTick;
        logic       gravityTick;
        moveCmd_t   moveCmd;
        logic [1:0] fireSlot;
        logic       landed;
        logic       atEdge;
        logic       slot0Exit;
        pos_t       playerPos;
        pos_t       laserPos [NUM_LASERS];

        ////////////////////////////////////////////////////////////////////////////
        // frame and gravity rates
        tickGen #(.DIV(FRAME_DIV)) frameTickGen (
                .CLK(CLK), .ARST_L(ARST_L), .tick_o(frameTick)
        );

        tickGen #(.DIV(GRAVITY_DIV)) gravityTickGen (
                .CLK(CLK), .ARST_L(ARST_L), .tick_o(gravityTick)
        );

        // key decode
        gameControl gameCtrl (
                .CLK(CLK), .ARST_L(ARST_L),
                .kbCode_i(KBCODE), .kbStrobe_i(KBSTROBE),
                .landed_i(landed), .atEdge_i(atEdge), .slot0Exit_i(slot0Exit),
                .moveCmd_o(moveCmd), .fireSlot_o(fireSlot)
        );

        // player and lasers
        playerMotion motion (
                .CLK(CLK), .ARST_L(ARST_L),
                .frameTick_i(frameTick), .gravityTick_i(gravityTick), .moveCmd_i(moveCmd),
                .playerPos_o(playerPos), .landed_o(landed), .atEdge_o(atEdge)
        );

        laserBank lasers (
                .CLK(CLK), .ARST_L(ARST_L),
                .frameTick_i(frameTick), .fireSlot_i(fireSlot), .playerPos_i(playerPos),
                .laserPos_o(laserPos), .slot0Exit_o(slot0Exit)
        );

        // pixel colour
        pixelRenderer renderer (
                .CLK(CLK), .ARST_L(ARST_L),
                .hCoord_i(HCOORD), .vCoord_i(VCOORD),
                .playerPos_i(playerPos), .laserPos_i(laserPos),
                .csel_o(CSEL)
        );

endmodule

`default_nettype wire

/* src/vgaGamePkg.sv */
`default_nettype none

package vgaGamePkg;

        // pixel coordinate, signed speed, 4:4:4 colour
        typedef logic [10:0]        coord_t;
        typedef logic signed [10:0] speed_t;
        typedef logic [11:0]        color_t;

        typedef struct packed {
                coord_t x;
                coord_t y;
        } pos_t;

        // walking speed plus one-cycle jump request
        typedef struct packed {
                speed_t xSpeed;
                logic   jumpKick;
        } moveCmd_t;

        // box offsets from the player's top-left corner, end exclusive
        typedef struct packed {
                logic [4:0] dx0;
                logic [4:0] dx1;
                logic [4:0] dy0;
                logic [4:0] dy1;
                color_t     color;
        } spriteRect_t;

        ////////////////////////////////////////////////////////////////////////////
        // keyboard scan codes
        localparam logic [7:0] KEY_RIGHT = 8'h23;
        localparam logic [7:0] KEY_LEFT  = 8'h1C;
        localparam logic [7:0] KEY_JUMP  = 8'h1D;
        localparam logic [7:0] KEY_FIRE  = 8'h29;

        // playfield limits
        localparam coord_t EDGE_MIN   = 11'd10;
        localparam coord_t EDGE_EAST  = 11'd630;
        localparam coord_t EDGE_SOUTH = 11'd471;
        localparam coord_t FLOOR_Y    = 11'd420;
        localparam coord_t REST_Y     = 11'd419;
        localparam coord_t START_X    = 11'd319;
        localparam coord_t START_Y    = 11'd239;

        // gun muzzle and laser box
        localparam coord_t MUZZLE_DX  = 11'd22;
        localparam coord_t MUZZLE_DY  = 11'd11;
        localparam coord_t LASER_W    = 11'd7;
        localparam coord_t LASER_H    = 11'd2;
        localparam int     NUM_LASERS = 3;

        localparam color_t COL_BG    = 12'hFFF;
        localparam color_t COL_LASER = 12'hF00;

        ////////////////////////////////////////////////////////////////////////////
        // player sprite, first match wins
        localparam spriteRect_t SPRITE [20] = '{
                '{5'd0,  5'd10, 5'd0,  5'd2,  12'h000},
                '{5'd2,  5'd10, 5'd2,  5'd4,  12'hFA5},
                '{5'd0,  5'd2,  5'd2,  5'd5,  12'h000},
                '{5'd2,  5'd6,  5'd4,  5'd5,  12'hFA5},
                '{5'd6,  5'd7,  5'd4,  5'd5,  12'hFFF},
                '{5'd7,  5'd8,  5'd4,  5'd5,  12'h00F},
                '{5'd8,  5'd10, 5'd4,  5'd5,  12'hFA5},
                '{5'd0,  5'd10, 5'd5,  5'd8,  12'hFA5},
                '{5'd6,  5'd10, 5'd8,  5'd9,  12'h000},
                '{5'd0,  5'd10, 5'd8,  5'd10, 12'hFA5},
                '{5'd3,  5'd7,  5'd10, 5'd12, 12'hFA5},
                '{5'd1,  5'd10, 5'd12, 5'd14, 12'h00F},
                '{5'd1,  5'd4,  5'd14, 5'd16, 12'h00F},
                '{5'd1,  5'd10, 5'd16, 5'd23, 12'h00F},
                '{5'd4,  5'd15, 5'd14, 5'd16, 12'hFA5},
                '{5'd3,  5'd5,  5'd23, 5'd27, 12'h000},
                '{5'd6,  5'd8,  5'd23, 5'd27, 12'h000},
                '{5'd13, 5'd22, 5'd11, 5'd13, 12'h000},
                '{5'd13, 5'd15, 5'd13, 5'd14, 12'h000},
                '{5'd13, 5'd15, 5'd16, 5'd17, 12'h000}
        };

endpackage

`default_nettype wire

/* tb/tbVgaGame.sv */
`timescale 1ns/1ps
`default_nettype none

module tbVgaGame
        import vgaGamePkg::*;
();

        localparam color_t BLACK      = 12'h000;
        localparam color_t SKIN       = 12'hFA5;
        localparam int     X0         = int'(START_X);
        localparam int     Y0         = int'(START_Y);
        localparam int     REST       = int'(REST_Y);
        localparam int     GUN_DX     = int'(MUZZLE_DX);
        localparam int     LASER_ROW  = int'(REST_Y) + int'(MUZZLE_DY);
        localparam int     SCAN_LIMIT = 20;

        logic       CLK = 1'b0;
        logic       ARST_L;
        logic [7:0] KBCODE;
        logic       KBSTROBE;
        logic [9:0] HCOORD;
        logic [9:0] VCOORD;
        color_t     CSEL;
        int         seed = 67;

        // 100 ns period
        always #50 CLK = !CLK;

        vgaGame #(.FRAME_DIV(20), .GRAVITY_DIV(80)) vgaGame_inst (
                .CLK(CLK), .ARST_L(ARST_L), .KBCODE(KBCODE), .KBSTROBE(KBSTROBE),
                .HCOORD(HCOORD), .VCOORD(VCOORD), .CSEL(CSEL)
        );

        ////////////////////////////////////////////////////////////////////////////
        // error exits
        task automatic stopOnError();
                $display("CHECKS FAILED");
                $fatal(1, "stopping at first error");
        endtask

        task automatic failRun(input string why);
                $display("%s", why);
                stopOnError();
        endtask

        task automatic checkValue(input string name, input int got, input int exp);
                assert (got == exp)
                else
                begin
                        $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
                        stopOnError();
                end
        endtask

        task automatic checkRange(input string name, input int got, input int lo, input int hi);
                assert ((got >= lo) && (got <= hi))
                else
                begin
                        $display("MISMATCH %s: got 0x%0h expected 0x%0h to 0x%0h",
                                 name, got, lo, hi);
                        stopOnError();
                end
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // expected colour from the sprite table, first box wins
        function automatic color_t spriteModel(input int px, input int py, input int ox,
                                               input int oy);
                color_t c;
                logic   hit;
                int     i;
                c   = COL_BG;
                hit = 1'b0;
                for (i = 0; i < 20; i++)
                begin
                        if (!hit && (px >= ox + int'(SPRITE[i].dx0))
                            && (px < ox + int'(SPRITE[i].dx1))
                            && (py >= oy + int'(SPRITE[i].dy0))
                            && (py < oy + int'(SPRITE[i].dy1)))
                        begin
                                c   = SPRITE[i].color;
                                hit = 1'b1;
                        end
                end
                return c;
        endfunction

        // one strobe cycle
        task automatic pressKey(input logic [7:0] code);
                @(posedge CLK);
                KBCODE   <= code;
                KBSTROBE <= 1'b1;
                @(posedge CLK);
                KBSTROBE <= 1'b0;
        endtask

        // colour lands one clock after the coordinate
        task automatic expectPixel(input int x, input int y, input color_t exp);
                @(posedge CLK);
                HCOORD <= 10'(x);
                VCOORD <= 10'(y);
                @(posedge CLK);
                @(negedge CLK);
                checkValue("CSEL", int'(CSEL), int'(exp));
        endtask

        // pipelined sweep, one pixel per clock, -1 when colour absent
        task automatic scanLine(input logic alongRow, input int fixed, input int first,
                                input int last, input color_t want, output int hit);
                int i;
                hit = -1;
                for (i = first; (i <= last + 1) && (hit < 0); i++)
                begin
                        @(posedge CLK);
                        if (i <= last)
                        begin
                                HCOORD <= alongRow ? 10'(i) : 10'(fixed);
                                VCOORD <= alongRow ? 10'(fixed) : 10'(i);
                        end
                        @(negedge CLK);
                        // csel here belongs to the previous coordinate
                        if ((i > first) && (CSEL == want))
                                hit = i - 1;
                end
        endtask

        // first hair row in a column
        task automatic topRow(input int col, output int row);
                scanLine(1'b0, col, 0, 479, BLACK, row);
        endtask

        // hair's left end on a row
        task automatic leftCol(input int row, output int col);
                scanLine(1'b1, row, 0, 639, BLACK, col);
        endtask

        task automatic settleAtRest(input int col);
                int top;
                int tries;
                top   = -1;
                tries = 0;
                while (top != REST)
                begin
                        if (tries == SCAN_LIMIT)
                                failRun("player never came to rest on the floor");
                        topRow(col, top);
                        tries++;
                end
        endtask

        // muzzle row empty once every laser has run off
        task automatic waitLaserGone();
                int red;
                int tries;
                red   = 0;
                tries = 0;
                while (red >= 0)
                begin
                        if (tries == SCAN_LIMIT)
                                failRun("laser never left the playfield");
                        scanLine(1'b1, LASER_ROW, 0, 639, COL_LASER, red);
                        tries++;
                end
        endtask

        ////////////////////////////////////////////////////////////////////////////
        initial
        begin
                int     x;
                int     y;
                int     r;
                int     top;
                int     col;
                int     prev;
                int     red;
                int     tries;
                int     playerX;
                ARST_L   = 1'b0;
                KBCODE   = '0;
                KBSTROBE = 1'b0;
                HCOORD   = '0;
                VCOORD   = '0;
                repeat (5) @(posedge CLK);
                ARST_L <= 1'b1;

                // reset picture, player still at start
                expectPixel(X0, Y0, BLACK);
                expectPixel(X0 + 2, Y0 + 2, SKIN);
                expectPixel(0, 0, COL_BG);
                repeat (10)
                begin
                        r = $random(seed);
                        x = X0 - 4 + ((r & 32'h7fff_ffff) % 30);
                        r = $random(seed);
                        y = Y0 - 4 + ((r & 32'h7fff_ffff) % 34);
                        expectPixel(x, y, spriteModel(x, y, X0, Y0));
                end

                // fall under gravity and stay down
                settleAtRest(X0 + 1);
                topRow(X0 + 1, top);
                checkValue("playerTop", top, REST);
                topRow(X0 + 1, top);
                checkValue("playerTop", top, REST);

                ////////////////////////////////////////////////////////////////////
                // walk right, stop, walk to the east wall
                pressKey(KEY_RIGHT);
                col   = -1;
                tries = 0;
                while (col <= X0)
                begin
                        if (tries == SCAN_LIMIT)
                                failRun("player did not walk right");
                        leftCol(REST, col);
                        tries++;
                end
                pressKey(KEY_RIGHT);
                leftCol(REST, prev);
                leftCol(REST, col);
                checkValue("playerX", col, prev);

                pressKey(KEY_RIGHT);
                tries = 0;
                while (col < 620)
                begin
                        if (tries == SCAN_LIMIT)
                                failRun("player never reached the east wall");
                        leftCol(REST, col);
                        tries++;
                end
                pressKey(KEY_RIGHT);
                leftCol(REST, col);
                checkRange("playerX", col, 620, 630);

                // back toward the middle so lasers have room
                pressKey(KEY_LEFT);
                tries = 0;
                while (!((col >= 0) && (col <= 400)))
                begin
                        if (tries == SCAN_LIMIT)
                                failRun("player did not walk back left");
                        leftCol(REST, col);
                        tries++;
                end
                pressKey(KEY_LEFT);
                leftCol(REST, playerX);

                ////////////////////////////////////////////////////////////////////
                // jump, a gravity tick at rest can swallow a kick so press again
                top   = REST;
                tries = 0;
                while ((top == REST) && (tries < 4))
                begin
                        pressKey(KEY_JUMP);
                        topRow(playerX + 1, top);
                        tries++;
                end
                checkRange("playerTop", top, 0, REST - 1);
                settleAtRest(playerX + 1);
                topRow(playerX + 1, top);
                checkValue("playerTop", top, REST);

                ////////////////////////////////////////////////////////////////////
                // laser leaves the muzzle and runs off the east edge
                pressKey(KEY_FIRE);
                scanLine(1'b1, LASER_ROW, 0, 639, COL_LASER, red);
                checkRange("laserX", red, playerX + GUN_DX, 639);
                waitLaserGone();

                // bank freed, full volley
                repeat (3) pressKey(KEY_FIRE);
                scanLine(1'b1, LASER_ROW, 0, 639, COL_LASER, red);
                checkRange("laserX", red, playerX + GUN_DX, 639);

                // volley gone, slot 0 exit reopens the bank
                waitLaserGone();
                pressKey(KEY_FIRE);
                scanLine(1'b1, LASER_ROW, 0, 639, COL_LASER, red);
                checkRange("laserX", red, playerX + GUN_DX, 639);

                $display("ALL CHECKS PASSED");
                $finish;
        end

endmodule

`default_nettype wire
